/* design/mont_collect.sv */
`timescale 1ns/1ps
`include "mont_defines.svh"

module mont_collect import mont_pkg::*; (
    input  logic           i_clk,
    input  logic           i_rst,
    mont_res_if.collect    res [`MONT_CORES],
    input  logic           i_pop,
    output logic           o_head_valid,
    output mont_word_t     o_head_m,
    output mont_tag_t      o_head_tag
);

    localparam int PTR_W = $clog2(`MONT_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`MONT_FIFO_DEPTH + 1);
    localparam int SEL_W = $clog2(`MONT_CORES);

    logic [`MONT_CORES-1:0] res_valid;
    logic [`MONT_CORES-1:0] grant;
    mont_word_t             res_m [`MONT_CORES];
    mont_tag_t              res_tag [`MONT_CORES];

    logic [SEL_W-1:0] rr_ptr;
    logic [SEL_W-1:0] idx;
    logic [SEL_W-1:0] sel;
    logic             found;
    logic             push;
    logic             pop;
    logic             full;

    mont_word_t       fifo_m [`MONT_FIFO_DEPTH];
    mont_tag_t        fifo_tag [`MONT_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    for (genvar g = 0; g < `MONT_CORES; g++) begin : g_res
        assign res_valid[g] = res[g].valid;
        assign res_m[g]     = res[g].m;
        assign res_tag[g]   = res[g].tag;
        assign res[g].ready = grant[g];
    end

    // Search from rr_ptr upward, index wraps with the power-of-two core count.
    always_comb begin
        sel   = rr_ptr;
        found = 1'b0;
        idx   = rr_ptr;
        for (int k = 0; k < `MONT_CORES; k++) begin
            idx = rr_ptr + SEL_W'(k);
            if (!found && res_valid[idx]) begin
                sel   = idx;
                found = 1'b1;
            end
        end
    end

    assign full  = (count == CNT_W'(`MONT_FIFO_DEPTH));
    assign push  = found & ~full;
    assign pop   = i_pop & o_head_valid;
    assign grant = {{(`MONT_CORES-1){1'b0}}, push} << sel;

    assign o_head_valid = (count != '0);
    assign o_head_m     = fifo_m[rd_ptr];
    assign o_head_tag   = fifo_tag[rd_ptr];

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            rr_ptr <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                rr_ptr <= sel + 1'b1; // Granted core goes to the back.
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge i_clk) begin
        if (push) begin
            fifo_m[wr_ptr]   <= res_m[sel];
            fifo_tag[wr_ptr] <= res_tag[sel];
        end
    end

endmodule

/* design/mont_core.sv */
`timescale 1ns/1ps
`include "mont_defines.svh"

module mont_core import mont_pkg::*; (
    input  logic    i_clk,
    input  logic    i_rst,
    mont_job_if.core job,
    mont_res_if.core res
);

    core_state_t state;
    mont_cnt_t   cnt;

    mont_word_t  n_r;
    mont_word_t  a_r; // Shifted right, bit 0 is the current bit of A.
    mont_word_t  b_r;
    mont_tag_t   tag_r;
    logic [`MONT_W:0]   m_r; // Stays below N+B, so one spare bit.

    logic [`MONT_W+1:0] sum_b;
    logic [`MONT_W+1:0] sum_n;
    logic [`MONT_W:0]   m_next;
    logic               m_ge_n;

    assign job.ready = (state == IDLE);
    assign res.valid = (state == DONE);
    assign res.m     = m_r[`MONT_W-1:0];
    assign res.tag   = tag_r;

    // Add B when the bit of A is set.
    assign sum_b = {1'b0, m_r} + ({(`MONT_W+2){a_r[0]}} & {2'b00, b_r});

    // Add N when the partial sum is odd, then halve.
    assign sum_n  = sum_b + ({(`MONT_W+2){sum_b[0]}} & {2'b00, n_r});
    assign m_next = sum_n[`MONT_W+1:1];

    assign m_ge_n = (m_r >= {1'b0, n_r});

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (job.valid) begin
                        state <= LOOP;
                        cnt   <= '0;
                    end
                end
                LOOP: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == mont_cnt_t'(`MONT_W-1)) begin
                        state <= FINAL;
                    end
                end
                FINAL: begin
                    state <= DONE;
                end
                DONE: begin
                    if (res.ready) begin
                        state <= IDLE; // Collected.
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        case (state)
            IDLE: begin
                if (job.valid) begin
                    n_r   <= job.n;
                    a_r   <= job.a;
                    b_r   <= job.b;
                    tag_r <= job.tag;
                    m_r   <= '0;
                end
            end
            LOOP: begin
                m_r <= m_next;
                a_r <= a_r >> 1;
            end
            FINAL: begin
                if (m_ge_n) begin
                    m_r <= m_r - {1'b0, n_r}; // Single subtraction, A and B below N.
                end
            end
            default: begin
                m_r <= m_r;
            end
        endcase
    end

endmodule

/* design/mont_dispatch.sv */
`timescale 1ns/1ps
`include "mont_defines.svh"

module mont_dispatch import mont_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst,
    input  logic         i_wb_cyc,
    input  logic         i_wb_stb,
    input  logic         i_wb_we,
    input  wb_adr_t      i_wb_adr,
    input  wb_data_t     i_wb_dat,
    output wb_data_t     o_wb_dat,
    output logic         o_wb_ack,
    mont_job_if.dispatch job [`MONT_CORES],
    input  logic         i_head_valid,
    input  mont_word_t   i_head_m,
    input  mont_tag_t    i_head_tag,
    output logic         o_pop
);

    mont_word_t n_reg;
    mont_word_t a_reg;
    mont_word_t b_reg;
    mont_word_t pend_n;
    mont_word_t pend_a;
    mont_word_t pend_b;
    mont_tag_t  pend_tag;
    mont_tag_t  next_tag;
    logic       pend_valid;

    logic [`MONT_CORES-1:0] core_ready;
    logic [`MONT_CORES-1:0] grant;
    logic                   issue;

    logic     bus_req;
    logic     wr_en;
    logic     go;
    wb_adr_t  res_off;
    logic [7:0] op_base;
    logic [7:0] res_base;
    wb_data_t status;
    wb_data_t rd_data;

    assign bus_req = i_wb_cyc & i_wb_stb & ~o_wb_ack; // One ack per strobe.
    assign wr_en   = bus_req & i_wb_we;
    assign go      = wr_en & (i_wb_adr == wb_adr_t'(`MONT_ADR_CTRL)) & ~pend_valid;
    assign o_pop   = wr_en & (i_wb_adr == wb_adr_t'(`MONT_ADR_POP));

    assign res_off  = i_wb_adr - wb_adr_t'(`MONT_ADR_RES);
    assign op_base  = {i_wb_adr[2:0], 5'd0}; // Operand bases are multiples of 8 words.
    assign res_base = {res_off[2:0], 5'd0};

    // Lowest ready core wins.
    assign grant = core_ready & (~core_ready + 1'b1);
    assign issue = pend_valid & (|core_ready);

    for (genvar g = 0; g < `MONT_CORES; g++) begin : g_job
        assign job[g].valid   = pend_valid & grant[g];
        assign job[g].n       = pend_n;
        assign job[g].a       = pend_a;
        assign job[g].b       = pend_b;
        assign job[g].tag     = pend_tag;
        assign core_ready[g]  = job[g].ready;
    end

    always_comb begin
        status                  = '0;
        status[0]               = pend_valid;
        status[1]               = i_head_valid;
        status[4 +: `MONT_TAG_W] = i_head_valid ? i_head_tag : '0;
        status[8 +: `MONT_TAG_W] = next_tag;
    end

    always_comb begin
        rd_data = '0;
        if (i_wb_adr < wb_adr_t'(`MONT_ADR_A)) begin
            rd_data = n_reg[op_base +: 32];
        end else if (i_wb_adr < wb_adr_t'(`MONT_ADR_B)) begin
            rd_data = a_reg[op_base +: 32];
        end else if (i_wb_adr < wb_adr_t'(`MONT_ADR_CTRL)) begin
            rd_data = b_reg[op_base +: 32];
        end else if (i_wb_adr == wb_adr_t'(`MONT_ADR_STATUS)) begin
            rd_data = status;
        end else if (i_wb_adr >= wb_adr_t'(`MONT_ADR_RES) &&
                     i_wb_adr < wb_adr_t'(`MONT_ADR_POP)) begin
            rd_data = i_head_m[res_base +: 32];
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_wb_ack   <= 1'b0;
            pend_valid <= 1'b0;
            next_tag   <= '0;
        end else begin
            o_wb_ack <= bus_req;
            if (go) begin
                pend_valid <= 1'b1;
                next_tag   <= next_tag + 1'b1;
            end else if (issue) begin
                pend_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (bus_req) begin
            o_wb_dat <= rd_data;
        end
        if (wr_en && i_wb_adr < wb_adr_t'(`MONT_ADR_A)) begin
            n_reg[op_base +: 32] <= i_wb_dat;
        end
        if (wr_en && i_wb_adr >= wb_adr_t'(`MONT_ADR_A) &&
            i_wb_adr < wb_adr_t'(`MONT_ADR_B)) begin
            a_reg[op_base +: 32] <= i_wb_dat;
        end
        if (wr_en && i_wb_adr >= wb_adr_t'(`MONT_ADR_B) &&
            i_wb_adr < wb_adr_t'(`MONT_ADR_CTRL)) begin
            b_reg[op_base +: 32] <= i_wb_dat;
        end
        if (go) begin
            pend_n   <= n_reg; // Snapshot, host may reload operands.
            pend_a   <= a_reg;
            pend_b   <= b_reg;
            pend_tag <= next_tag;
        end
    end

endmodule

/* design/mont_if.sv */
`timescale 1ns/1ps

interface mont_job_if import mont_pkg::*; ();
    logic       valid;
    logic       ready;
    mont_word_t n;
    mont_word_t a;
    mont_word_t b;
    mont_tag_t  tag;

    modport dispatch (
        output valid,
        output n,
        output a,
        output b,
        output tag,
        input  ready
    );

    modport core (
        input  valid,
        input  n,
        input  a,
        input  b,
        input  tag,
        output ready
    );
endinterface

interface mont_res_if import mont_pkg::*; ();
    logic       valid; // Held with m and tag until ready.
    logic       ready;
    mont_word_t m;
    mont_tag_t  tag;

    modport core (output valid, output m, output tag, input ready);

    modport collect (input valid, input m, input tag, output ready);
endinterface

/* design/mont_pkg.sv */
`include "mont_defines.svh"

package mont_pkg;

    typedef logic [`MONT_W-1:0]     mont_word_t; // Operand or result.
    typedef logic [`MONT_TAG_W-1:0] mont_tag_t;
    typedef logic [`MONT_CNT_W-1:0] mont_cnt_t;  // Bit index in the loop.

    typedef logic [31:0] wb_data_t;
    typedef logic [5:0]  wb_adr_t;               // Word address.

    // Core sequence.
    typedef enum logic [1:0] {
        IDLE,
        LOOP,
        FINAL,
        DONE
    } core_state_t;

endpackage

/* design/mont_top.sv */
`timescale 1ns/1ps
`include "mont_defines.svh"

module mont_top import mont_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_wb_cyc,
    input  logic     i_wb_stb,
    input  logic     i_wb_we,
    input  wb_adr_t  i_wb_adr,
    input  wb_data_t i_wb_dat,
    output wb_data_t o_wb_dat,
    output logic     o_wb_ack
);

    mont_job_if job [`MONT_CORES] ();
    mont_res_if res [`MONT_CORES] ();

    logic       head_valid;
    mont_word_t head_m;
    mont_tag_t  head_tag;
    logic       pop;

    mont_dispatch u_dispatch (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_wb_cyc     (i_wb_cyc),
        .i_wb_stb     (i_wb_stb),
        .i_wb_we      (i_wb_we),
        .i_wb_adr     (i_wb_adr),
        .i_wb_dat     (i_wb_dat),
        .o_wb_dat     (o_wb_dat),
        .o_wb_ack     (o_wb_ack),
        .job          (job),
        .i_head_valid (head_valid),
        .i_head_m     (head_m),
        .i_head_tag   (head_tag),
        .o_pop        (pop)
    );

    for (genvar g = 0; g < `MONT_CORES; g++) begin : g_core
        mont_core u_core (
            .i_clk (i_clk),
            .i_rst (i_rst),
            .job   (job[g]),
            .res   (res[g])
        );
    end

    mont_collect u_collect (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .res          (res),
        .i_pop        (pop),
        .o_head_valid (head_valid),
        .o_head_m     (head_m),
        .o_head_tag   (head_tag)
    );

endmodule

/* include/mont_defines.svh */
`ifndef MONT_DEFINES_SVH
`define MONT_DEFINES_SVH

`define MONT_W          256 // Operand width.
`define MONT_WORDS      8   // Bus words per operand.
`define MONT_CORES      4
`define MONT_TAG_W      4
`define MONT_FIFO_DEPTH 4
`define MONT_CNT_W      9

`define MONT_ADR_N      0   // Words 0 to 7, LSW first.
`define MONT_ADR_A      8
`define MONT_ADR_B      16
`define MONT_ADR_CTRL   24  // Any write issues GO.
`define MONT_ADR_STATUS 25
`define MONT_ADR_RES    26  // Words 26 to 33, FIFO head.
`define MONT_ADR_POP    34

`endif

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module mont_tb -o mont_sim

output=$(./obj_dir/mont_sim 2>&1 || true)
echo "$output"

echo "$output" | grep -qx "Testbench passed"

/* sim.f */
+incdir+include
design/mont_pkg.sv
design/mont_if.sv
design/mont_dispatch.sv
design/mont_core.sv
design/mont_collect.sv
design/mont_top.sv
verif/mont_assert.sv
verif/mont_tb.sv

/* verif/mont_assert.sv */
`timescale 1ns/1ps

module mont_assert (
    input logic i_clk,
    input logic i_rst,
    input logic i_wb_cyc,
    input logic i_wb_stb,
    input logic o_wb_ack
);

    // Single-cycle ack.
    a_ack_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        o_wb_ack |=> !o_wb_ack)
        else $error("ack held for more than one cycle");

    a_ack_after_stb: assert property (@(posedge i_clk) disable iff (i_rst)
        o_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
        else $error("ack without a strobe on the previous clock");

    a_ack_in_cyc: assert property (@(posedge i_clk) disable iff (i_rst)
        o_wb_ack |-> i_wb_cyc)
        else $error("ack outside a bus cycle");

    a_ack_reset: assert property (@(posedge i_clk)
        i_rst |-> !o_wb_ack)
        else $error("ack high during reset");

endmodule

bind mont_top mont_assert u_assert (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_wb_cyc (i_wb_cyc),
    .i_wb_stb (i_wb_stb),
    .o_wb_ack (o_wb_ack)
);

/* verif/mont_tb.sv */
`timescale 1ns/1ps
`include "mont_defines.svh"

module mont_tb import mont_pkg::*;;

    localparam int NUM_REC  = 6;
    localparam int REC_W    = 5;                 // N, A, B, M, drain delay.
    localparam int NUM_JOBS = 1 + 4 + 6 + 8 + 5;

    logic     clk;
    logic     rst;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_adr_t  wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;

    mont_word_t trace_mem [NUM_REC*REC_W];
    int         tag_rec [1 << `MONT_TAG_W];      // Record of each live tag or -1 when free.
    mont_tag_t  exp_tag;
    int         watchdog_cyc = 0;

    mont_top UUT (
        .i_clk    (clk),
        .i_rst    (rst),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_dat_w),
        .o_wb_dat (wb_dat_r),
        .o_wb_ack (wb_ack)
    );

    always #50 clk = ~clk;

    task automatic check_eq(input mont_word_t got, input mont_word_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    // One classic cycle after a random idle gap.
    task automatic bus_cycle(input logic wr, input int adr, input wb_data_t wdat,
                             output wb_data_t rdat);
        int gap;
        gap = int'($urandom_range(3, 0));
        repeat (gap + 1) @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= wr;
        wb_adr   <= wb_adr_t'(adr);
        wb_dat_w <= wdat;
        do begin
            @(posedge clk);
        end while (!wb_ack);
        rdat = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_write(input int adr, input wb_data_t data);
        wb_data_t unused_rd;
        bus_cycle(1'b1, adr, data, unused_rd);
    endtask

    task automatic bus_read(input int adr, output wb_data_t data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    function automatic mont_word_t rec_val(input int r, input int k);
        return trace_mem[r*REC_W + k];
    endfunction

    task automatic write_operand(input int base, input mont_word_t value);
        for (int w = 0; w < `MONT_WORDS; w++) begin
            bus_write(base + w, value[w*32 +: 32]);
        end
    endtask

    task automatic load_job(input int r);
        write_operand(`MONT_ADR_N, rec_val(r, 0));
        write_operand(`MONT_ADR_A, rec_val(r, 1));
        write_operand(`MONT_ADR_B, rec_val(r, 2));
    endtask

    task automatic clear_tags();
        foreach (tag_rec[t]) begin
            tag_rec[t] = -1;
        end
    endtask

    // Waits until no job is pending so the GO is accepted.
    task automatic go_job(input int r);
        wb_data_t status;
        do begin
            bus_read(`MONT_ADR_STATUS, status);
        end while (status[0]);
        check_eq(mont_word_t'(status[11:8]), mont_word_t'(exp_tag), "next tag before GO");
        tag_rec[exp_tag] = r;
        bus_write(`MONT_ADR_CTRL, 32'h1);
        exp_tag = exp_tag + 1'b1;
    endtask

    task automatic collect_batch(input int count, input logic drain);
        wb_data_t   status;
        wb_data_t   word;
        mont_word_t m;
        mont_tag_t  tag;
        for (int i = 0; i < count; i++) begin
            do begin
                bus_read(`MONT_ADR_STATUS, status);
            end while (!status[1]);
            tag = status[7:4];
            check_eq(mont_word_t'(tag_rec[tag] >= 0), 256'd1,
                     $sformatf("tag %0d issued and not yet seen", tag));
            for (int w = 0; w < `MONT_WORDS; w++) begin
                bus_read(`MONT_ADR_RES + w, word);
                m[w*32 +: 32] = word;
            end
            check_eq(m, rec_val(tag_rec[tag], 3), $sformatf("result M of tag %0d", tag));
            if (drain) begin
                repeat (int'(rec_val(tag_rec[tag], 4))) @(posedge clk);
            end
            tag_rec[tag] = -1;
            bus_write(`MONT_ADR_POP, 32'h0);
        end
        bus_read(`MONT_ADR_STATUS, status);
        check_eq(mont_word_t'(status[1:0]), '0, "STATUS flags after batch");
    endtask

    initial begin
        wait (watchdog_cyc > 0);
        repeat (watchdog_cyc) @(posedge clk);
        $display("ERROR: run timed out after %0d cycles", watchdog_cyc);
        $display("Testbench failed");
        $fatal(1, "Watchdog expired.");
    end

    initial begin
        wb_data_t   rd;
        mont_word_t op;
        mont_tag_t  held_tag;
        void'($urandom(57));
        clk      = 1'b0;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        exp_tag  = '0;
        $readmemh("verif/mont_trace.txt", trace_mem);
        watchdog_cyc = NUM_JOBS * 400 + 2000;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Reset state and operand readback.
        bus_read(`MONT_ADR_STATUS, rd);
        check_eq(mont_word_t'(rd), '0, "STATUS after reset");
        load_job(1);
        for (int w = 0; w < 3 * `MONT_WORDS; w++) begin
            bus_read(w, rd);
            op = rec_val(1, w / `MONT_WORDS);
            check_eq(mont_word_t'(rd), mont_word_t'(op[(w % `MONT_WORDS)*32 +: 32]),
                     $sformatf("operand word %0d readback", w));
        end

        clear_tags();
        load_job(0);
        go_job(0);
        collect_batch(1, 1'b0);

        clear_tags();
        for (int j = 0; j < 4; j++) begin
            load_job(j);
            go_job(j);
        end
        collect_batch(4, 1'b0);

        clear_tags();
        for (int j = 0; j < 6; j++) begin
            load_job(j % NUM_REC);
            go_job(j % NUM_REC);
        end
        collect_batch(6, 1'b0);

        // Slow draining fills the FIFO and stalls the cores.
        clear_tags();
        for (int j = 0; j < 8; j++) begin
            load_job(j % NUM_REC);
            go_job(j % NUM_REC);
        end
        collect_batch(8, 1'b1);

        // Fifth job stays pending and an extra GO must be dropped.
        clear_tags();
        load_job(4);
        for (int j = 0; j < 5; j++) begin
            go_job(4);
        end
        bus_read(`MONT_ADR_STATUS, rd);
        check_eq(mont_word_t'(rd[0]), 256'd1, "pending flag with all cores busy");
        held_tag = rd[11:8];
        bus_write(`MONT_ADR_CTRL, 32'h1);
        bus_read(`MONT_ADR_STATUS, rd);
        check_eq(mont_word_t'(rd[11:8]), mont_word_t'(held_tag), "next tag after dropped GO");
        check_eq(mont_word_t'(rd[11:8]), mont_word_t'(exp_tag), "tag count of accepted GOs");
        collect_batch(5, 1'b0);

        $display("Testbench passed");
        $finish;
    end

endmodule

/* verif/mont_trace.txt */
// One hex value per line: N, A, B, expected M, drain delay in cycles.
// Five lines make one job record.
7
3
5
4
0
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
0123456789ABCDEFFEDCBA98765432100F1E2D3C4B5A69788796A5B4C3D2E1F0
100000000
89ABCDEFFEDCBA98765432100F1E2D3C4B5A69788796A5B4C3D2E1F001234567
28
B
4
6
A
0
100000000000000000000000000000001
100000000000000000000000000000000
100000000000000000000000000000000
1
12C
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFE
2
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFD
14
10000000000000001
10000000000000000
3
FFFFFFFFFFFFFFFE
258
